//--- verilog/control_pkg.sv
`default_nettype none

package control_pkg;

  // Bus widths with a meaning of their own
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;
  typedef logic [39:0] resp_t;
  typedef logic [11:0] sensor_t;    // Telemetry ADC value
  typedef logic [9:0]  hang_t;      // Milliseconds
  typedef logic [1:0]  slot_t;      // Status slot index

  // Response FSM, one echo can be pending
  typedef enum logic [1:0] {
    RESP_IDLE    = 2'b00,
    RESP_PENDING = 2'b01
  } resp_state_t;

  // Command addresses
  localparam cmd_addr_t CMD_ADDR_CONFIG = 6'h09;
  localparam cmd_addr_t CMD_ADDR_CWHANG = 6'h10;

  // Bit positions in config command data
  localparam int CFG_VNA_BIT  = 23;
  localparam int CFG_TUNE_BIT = 20;

  // CW key delay line length in ms
  localparam int CW_DELAY_MS = 17;

  // Minimum power hold after key up, covers delay line plus decay
  localparam hang_t KEY_UP_TIMEOUT = 10'd41;

endpackage

`default_nettype wire

//--- verilog/debounce.sv
`timescale 1ns/1ps
`default_nettype none

module debounce #(
  parameter int DEBOUNCE_CYCLES = 16250
) (
  input  wire  clk,
  input  wire  rst_i,
  input  wire  pin_i,
  output logic clean_o
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [CNT_W-1:0] stable_cnt;   // Clocks the pin has held its new level

  // Output only moves after the pin stays at its new level long enough
  always_ff @(posedge clk) begin
    if (rst_i) begin
      stable_cnt <= '0;
      clean_o    <= 1'b0;
    end else if (pin_i == clean_o) begin
      stable_cnt <= '0;           // No change pending or bounced back
    end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES)) begin
      stable_cnt <= '0;
      clean_o    <= pin_i;
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/key_inputs.sv
`timescale 1ns/1ps
`default_nettype none

module key_inputs #(
  parameter int DEBOUNCE_CYCLES = 16250
) (
  input  wire  clk,
  input  wire  rst_i,
  input  wire  phone_tip_i,       // CW key, active low
  input  wire  phone_ring_i,      // PTT, active low
  input  wire  cn8_i,             // TX inhibit, active low
  output logic ext_cwkey_o,
  output logic ext_ptt_o,
  output logic ext_txinhibit_o,
  output logic key_tip_sync_o
);

  // Pin order is {cn8, ring, tip}
  logic [2:0] pin_meta;
  logic [2:0] pin_sync;

  // Two-flop synchronizer, idles at the released level
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pin_meta <= 3'b111;
      pin_sync <= 3'b111;
    end else begin
      pin_meta <= {cn8_i, phone_ring_i, phone_tip_i};
      pin_sync <= pin_meta;
    end
  end

  // Fast path for CW power on, skips the debounce
  assign key_tip_sync_o = pin_sync[0];

  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_db_cwkey (
    .clk(clk), .rst_i(rst_i), .pin_i(~pin_sync[0]), .clean_o(ext_cwkey_o)
  );

  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_db_ptt (
    .clk(clk), .rst_i(rst_i), .pin_i(~pin_sync[1]), .clean_o(ext_ptt_o)
  );

  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_db_txinhibit (
    .clk(clk), .rst_i(rst_i), .pin_i(~pin_sync[2]), .clean_o(ext_txinhibit_o)
  );

endmodule

`default_nettype wire

//--- verilog/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire                    cmd_rqst_i,
  input  wire control_pkg::cmd_addr_t cmd_addr_i,
  input  wire control_pkg::cmd_data_t cmd_data_i,
  input  wire                    cmd_ptt_i,
  output logic                   vna_o,
  output logic                   auto_tune_o,
  output logic                   int_ptt_o,
  output control_pkg::hang_t     cw_hang_time_o
);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      vna_o          <= 1'b0;
      auto_tune_o    <= 1'b0;
      int_ptt_o      <= 1'b0;
      cw_hang_time_o <= '0;
    end else if (cmd_rqst_i) begin
      int_ptt_o <= cmd_ptt_i;     // Every command carries PTT
      if (cmd_addr_i == control_pkg::CMD_ADDR_CONFIG) begin
        vna_o       <= cmd_data_i[control_pkg::CFG_VNA_BIT];
        auto_tune_o <= cmd_data_i[control_pkg::CFG_TUNE_BIT]; // ATU start/stop
      end else if (cmd_addr_i == control_pkg::CMD_ADDR_CWHANG) begin
        // Hang time is split over two fields
        cw_hang_time_o <= {cmd_data_i[31:24], cmd_data_i[17:16]};
      end
    end
  end

  // Host side must present a clean address with each strobe
  a_addr_known: assert property (
    @(posedge clk) disable iff (rst_i)
    cmd_rqst_i |-> !$isunknown(cmd_addr_i)
  ) else $error("cmd_decode: unknown cmd_addr_i with cmd_rqst_i");

endmodule

`default_nettype wire

//--- verilog/tx_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_sequencer #(
  parameter int MS_CYCLES = 2500
) (
  input  wire                clk,
  input  wire                rst_i,
  input  wire                run_i,
  input  wire                int_ptt_i,
  input  wire                vna_i,
  input  wire control_pkg::hang_t cw_hang_time_i,
  input  wire                ext_cwkey_i,
  input  wire                ext_ptt_i,
  input  wire                ext_txinhibit_i,
  input  wire                key_tip_sync_i,   // Raw tip, active low
  output logic               tx_on_o,
  output logic               cw_keydown_o,
  output logic               pa_inttr_o,
  output logic               pa_exttr_o,
  output logic               env_pa_o,
  output logic               env_op_o,
  output logic               rfsw_sel_o
);

  localparam int MS_W = $clog2(MS_CYCLES);

  logic [MS_W-1:0]                   ms_count;
  logic                              ms_tick;
  logic [control_pkg::CW_DELAY_MS-1:0] cw_delay_line;  // One ms per stage
  control_pkg::hang_t                cw_power_timeout;
  logic                              cw_hang_phase;  // 0 minimum hold, 1 hang time
  logic                              cw_power_on;
  logic                              tx_power_on;

  // Free-running millisecond tick
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ms_count <= '0;
      ms_tick  <= 1'b0;
    end else if (ms_count == MS_W'(MS_CYCLES - 1)) begin
      ms_count <= '0;
      ms_tick  <= 1'b1;
    end else begin
      ms_count <= ms_count + 1'b1;
      ms_tick  <= 1'b0;
    end
  end

  // Delay the key so relays and PA settle before the envelope starts
  always_ff @(posedge clk) begin
    if (rst_i) begin
      cw_delay_line <= '0;
    end else if (ms_tick) begin
      cw_delay_line <= {cw_delay_line[control_pkg::CW_DELAY_MS-2:0], ext_cwkey_i};
    end
  end

  assign cw_keydown_o = cw_delay_line[control_pkg::CW_DELAY_MS-1];

  // Power comes on at the first key press and is held after release
  always_ff @(posedge clk) begin
    if (rst_i) begin
      cw_power_timeout <= '0;
      cw_hang_phase    <= 1'b0;
      cw_power_on      <= 1'b0;
    end else if (!key_tip_sync_i) begin
      cw_power_timeout <= control_pkg::KEY_UP_TIMEOUT;
      cw_hang_phase    <= 1'b0;
      cw_power_on      <= 1'b1;
    end else if (ms_tick) begin
      if (cw_power_timeout != '0) begin
        cw_power_timeout <= cw_power_timeout - 1'b1;
      end else if (!cw_hang_phase) begin
        cw_power_timeout <= cw_hang_time_i;   // Second phase, user hang time
        cw_hang_phase    <= 1'b1;
      end else begin
        cw_power_on <= 1'b0;
      end
    end
  end

  assign tx_on_o = (int_ptt_i | cw_keydown_o | ext_ptt_i) & ~ext_txinhibit_i & run_i;

  assign tx_power_on = cw_power_on | tx_on_o;

  // PA and envelope enables
  assign pa_inttr_o = tx_power_on & ~vna_i;
  assign env_pa_o   = tx_power_on & ~vna_i;
  assign env_op_o   = tx_power_on;
  assign pa_exttr_o = tx_power_on;
  assign rfsw_sel_o = ~vna_i;           // VNA mode bypasses the PA path

  // Inhibit pin from key_inputs must block any new transmit
  a_inhibit_blocks_tx: assert property (
    @(posedge clk) disable iff (rst_i)
    $rose(tx_on_o) |-> !ext_txinhibit_i
  ) else $error("tx_sequencer: tx_on_o rose while TX inhibit active");

endmodule

`default_nettype wire

//--- verilog/resp_builder.sv
`timescale 1ns/1ps
`default_nettype none

module resp_builder #(
  parameter logic [7:0] SERIAL_NO = 8'h00
) (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire                    cmd_rqst_i,
  input  wire                    cmd_requires_resp_i,
  input  wire control_pkg::cmd_addr_t cmd_addr_i,
  input  wire control_pkg::cmd_data_t cmd_data_i,
  input  wire                    resp_rqst_i,
  input  wire                    tx_on_i,
  input  wire                    ext_cwkey_i,
  input  wire                    ext_ptt_i,
  input  wire                    rxclip_i,
  input  wire control_pkg::sensor_t fwd_pwr_i,
  input  wire control_pkg::sensor_t rev_pwr_i,
  input  wire control_pkg::sensor_t bias_current_i,
  input  wire control_pkg::sensor_t temperature_i,
  output control_pkg::resp_t     resp_o
);

  control_pkg::resp_state_t resp_state;
  control_pkg::resp_state_t resp_state_next;
  control_pkg::cmd_addr_t   echo_addr;
  control_pkg::cmd_data_t   echo_data;
  control_pkg::slot_t       slot_idx;
  logic [1:0]               clip_cnt;
  logic                     clip_flag;
  logic                     capture;
  logic [31:0]              slot_payload;

  assign capture   = cmd_rqst_i & cmd_requires_resp_i;
  assign clip_flag = &clip_cnt;

  // One-deep queue where a newer command replaces the pending one
  always_comb begin
    resp_state_next = resp_state;
    case (resp_state)
      control_pkg::RESP_IDLE: begin
        if (capture) resp_state_next = control_pkg::RESP_PENDING;
      end
      control_pkg::RESP_PENDING: begin
        if (resp_rqst_i && !capture) resp_state_next = control_pkg::RESP_IDLE;
      end
      default: resp_state_next = control_pkg::RESP_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) resp_state <= control_pkg::RESP_IDLE;
    else       resp_state <= resp_state_next;
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      echo_addr <= cmd_addr_i;
      echo_data <= cmd_data_i;
    end
  end

  // Low 32 bits of each status slot
  always_comb begin
    case (slot_idx)
      2'd0:    slot_payload = {7'h00, clip_flag, 16'h0000, SERIAL_NO};
      2'd1:    slot_payload = {4'h0, temperature_i, 4'h0, fwd_pwr_i};
      2'd2:    slot_payload = {4'h0, rev_pwr_i, 4'h0, bias_current_i};
      default: slot_payload = 32'h0000_0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      resp_o   <= {32'h0000_0000, SERIAL_NO};
      slot_idx <= '0;
      clip_cnt <= 2'b00;
    end else if (resp_rqst_i) begin
      slot_idx <= slot_idx + 1'b1;  // Advances even when an echo is sent
      clip_cnt <= 2'b00;
      if (resp_state == control_pkg::RESP_PENDING) begin
        resp_o <= {1'b1, echo_addr, tx_on_i, echo_data};
      end else begin
        resp_o <= {3'b000, slot_idx, 1'b0, ext_cwkey_i, ext_ptt_i, slot_payload};
      end
    end else if (!clip_flag) begin
      clip_cnt <= clip_cnt + {1'b0, rxclip_i}; // Saturates at 3
    end
  end

  a_state_legal: assert property (
    @(posedge clk) disable iff (rst_i)
    resp_state inside {control_pkg::RESP_IDLE, control_pkg::RESP_PENDING}
  ) else $error("resp_builder: illegal response FSM state");

endmodule

`default_nettype wire

//--- verilog/control_top.sv
`timescale 1ns/1ps
`default_nettype none

module control_top #(
  parameter int         MS_CYCLES       = 2500,
  parameter int         DEBOUNCE_CYCLES = 16250,
  parameter logic [7:0] SERIAL_NO       = 8'h00
) (
  input  wire                    clk,
  input  wire                    rst_i,
  // Command and response strobes
  input  wire                    cmd_rqst_i,
  input  wire control_pkg::cmd_addr_t cmd_addr_i,
  input  wire control_pkg::cmd_data_t cmd_data_i,
  input  wire                    cmd_ptt_i,
  input  wire                    cmd_requires_resp_i,
  input  wire                    resp_rqst_i,
  input  wire                    run_i,
  input  wire                    rxclip_i,
  // Key pins, active low
  input  wire                    phone_tip_i,
  input  wire                    phone_ring_i,
  input  wire                    cn8_i,
  // Telemetry
  input  wire control_pkg::sensor_t fwd_pwr_i,
  input  wire control_pkg::sensor_t rev_pwr_i,
  input  wire control_pkg::sensor_t bias_current_i,
  input  wire control_pkg::sensor_t temperature_i,
  // Outputs
  output logic                   tx_on_o,
  output logic                   cw_keydown_o,
  output logic                   pa_inttr_o,
  output logic                   pa_exttr_o,
  output logic                   env_pa_o,
  output logic                   env_op_o,
  output logic                   rfsw_sel_o,
  output logic                   auto_tune_o,
  output control_pkg::resp_t     resp_o
);

  logic               ext_cwkey;
  logic               ext_ptt;
  logic               ext_txinhibit;
  logic               key_tip_sync;
  logic               vna;
  logic               int_ptt;
  control_pkg::hang_t cw_hang_time;

  key_inputs #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_inputs (
    .clk             (clk),
    .rst_i           (rst_i),
    .phone_tip_i     (phone_tip_i),
    .phone_ring_i    (phone_ring_i),
    .cn8_i           (cn8_i),
    .ext_cwkey_o     (ext_cwkey),
    .ext_ptt_o       (ext_ptt),
    .ext_txinhibit_o (ext_txinhibit),
    .key_tip_sync_o  (key_tip_sync)
  );

  cmd_decode u_cmd_decode (
    .clk            (clk),
    .rst_i          (rst_i),
    .cmd_rqst_i     (cmd_rqst_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_data_i     (cmd_data_i),
    .cmd_ptt_i      (cmd_ptt_i),
    .vna_o          (vna),
    .auto_tune_o    (auto_tune_o),
    .int_ptt_o      (int_ptt),
    .cw_hang_time_o (cw_hang_time)
  );

  tx_sequencer #(.MS_CYCLES(MS_CYCLES)) u_tx_sequencer (
    .clk             (clk),
    .rst_i           (rst_i),
    .run_i           (run_i),
    .int_ptt_i       (int_ptt),
    .vna_i           (vna),
    .cw_hang_time_i  (cw_hang_time),
    .ext_cwkey_i     (ext_cwkey),
    .ext_ptt_i       (ext_ptt),
    .ext_txinhibit_i (ext_txinhibit),
    .key_tip_sync_i  (key_tip_sync),
    .tx_on_o         (tx_on_o),
    .cw_keydown_o    (cw_keydown_o),
    .pa_inttr_o      (pa_inttr_o),
    .pa_exttr_o      (pa_exttr_o),
    .env_pa_o        (env_pa_o),
    .env_op_o        (env_op_o),
    .rfsw_sel_o      (rfsw_sel_o)
  );

  resp_builder #(.SERIAL_NO(SERIAL_NO)) u_resp_builder (
    .clk                 (clk),
    .rst_i               (rst_i),
    .cmd_rqst_i          (cmd_rqst_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .resp_rqst_i         (resp_rqst_i),
    .tx_on_i             (tx_on_o),
    .ext_cwkey_i         (ext_cwkey),
    .ext_ptt_i           (ext_ptt),
    .rxclip_i            (rxclip_i),
    .fwd_pwr_i           (fwd_pwr_i),
    .rev_pwr_i           (rev_pwr_i),
    .bias_current_i      (bias_current_i),
    .temperature_i       (temperature_i),
    .resp_o              (resp_o)
  );

endmodule

`default_nettype wire

//--- test/tb_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_control;

  localparam int         MS_CYCLES       = 8;
  localparam int         DEBOUNCE_CYCLES = 4;
  localparam logic [7:0] SERIAL_NO       = 8'h5A;
  localparam int         CLK_NS          = 8;
  localparam int         SETTLE          = DEBOUNCE_CYCLES + 6;  // Sync and debounce with margin
  localparam int         CW_EARLY        = 16 * MS_CYCLES;
  // Sync, debounce and up to 17 tick periods
  localparam int         CW_LATE         = 17 * MS_CYCLES + DEBOUNCE_CYCLES + 3;
  localparam int         WATCHDOG_NS     = 3000 * MS_CYCLES * CLK_NS;

  logic clk, rst_i;
  logic cmd_rqst_i, cmd_ptt_i, cmd_requires_resp_i, resp_rqst_i, run_i, rxclip_i;
  logic phone_tip_i, phone_ring_i, cn8_i;
  control_pkg::cmd_addr_t cmd_addr_i;
  control_pkg::cmd_data_t cmd_data_i;
  control_pkg::sensor_t   fwd_pwr_i, rev_pwr_i, bias_current_i, temperature_i;
  logic tx_on_o, cw_keydown_o, pa_inttr_o, pa_exttr_o, env_pa_o, env_op_o;
  logic rfsw_sel_o, auto_tune_o;
  control_pkg::resp_t     resp_o;

  // Reference model state
  logic [2:0]             pins_q;     // {cn8, ring, tip} as last sampled
  logic [15:0]            pin_age;    // Clocks since any key pin changed
  logic                   ptt_m, vna_m, tune_m, pend_m, resp_chk;
  control_pkg::hang_t     hang_m;
  control_pkg::cmd_addr_t echo_addr_m;
  control_pkg::cmd_data_t echo_data_m;
  control_pkg::slot_t     slot_m;
  logic [1:0]             clip_m;
  control_pkg::resp_t     exp_resp;
  logic                   exp_tx;
  logic                   ptt_phase, hang_chk;
  int                     hold_min, hold_max;
  int                     value_errs, other_errs;

  control_top #(
    .MS_CYCLES(MS_CYCLES), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .SERIAL_NO(SERIAL_NO)
  ) u_control_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  // Expected status word with the key pins released
  function automatic control_pkg::resp_t status_word(input control_pkg::slot_t slot,
                                                      input logic clip);
    control_pkg::resp_t w;
    w = '0;
    w[36:35] = slot;
    case (slot)
      2'd0: begin
        w[24]  = clip;
        w[7:0] = SERIAL_NO;
      end
      2'd1: begin
        w[27:16] = temperature_i;
        w[11:0]  = fwd_pwr_i;
      end
      2'd2: begin
        w[27:16] = rev_pwr_i;
        w[11:0]  = bias_current_i;
      end
      default: ;
    endcase
    return w;
  endfunction

  always @(posedge clk) begin
    if (rst_i) begin
      pins_q      <= 3'b111;
      pin_age     <= '0;
      ptt_m       <= 1'b0;
      vna_m       <= 1'b0;
      tune_m      <= 1'b0;
      hang_m      <= '0;
      pend_m      <= 1'b0;
      echo_addr_m <= '0;
      echo_data_m <= '0;
      slot_m      <= '0;
      clip_m      <= 2'd0;
      resp_chk    <= 1'b0;
      exp_resp    <= '0;
    end else begin
      pins_q <= {cn8_i, phone_ring_i, phone_tip_i};
      if ({cn8_i, phone_ring_i, phone_tip_i} != pins_q) pin_age <= '0;
      else if (pin_age != 16'hFFFF) pin_age <= pin_age + 16'd1;
      if (cmd_rqst_i) begin
        ptt_m <= cmd_ptt_i;
        if (cmd_addr_i == control_pkg::CMD_ADDR_CONFIG) begin
          vna_m  <= cmd_data_i[control_pkg::CFG_VNA_BIT];
          tune_m <= cmd_data_i[control_pkg::CFG_TUNE_BIT];
        end
        if (cmd_addr_i == control_pkg::CMD_ADDR_CWHANG)
          hang_m <= {cmd_data_i[31:24], cmd_data_i[17:16]};
      end
      resp_chk <= resp_rqst_i;
      if (resp_rqst_i) begin
        slot_m <= slot_m + 2'd1;
        clip_m <= 2'd0;
        if (pend_m) exp_resp <= {1'b1, echo_addr_m, 1'b0, echo_data_m};  // run_i low here
        else        exp_resp <= status_word(slot_m, clip_m == 2'd3);
      end else if (rxclip_i && clip_m != 2'd3) begin
        clip_m <= clip_m + 2'd1;
      end
      if (cmd_rqst_i && cmd_requires_resp_i) begin
        pend_m      <= 1'b1;
        echo_addr_m <= cmd_addr_i;
        echo_data_m <= cmd_data_i;
      end else if (resp_rqst_i) begin
        pend_m <= 1'b0;
      end
    end
  end

  assign exp_tx   = (ptt_m | ~pins_q[1]) & pins_q[2] & run_i;
  assign hold_min = (int'(control_pkg::KEY_UP_TIMEOUT) + int'(hang_m)) * MS_CYCLES;
  assign hold_max = (int'(control_pkg::KEY_UP_TIMEOUT) + int'(hang_m) + 2) * MS_CYCLES + 2;

  a_rfsw: assert property (@(posedge clk) disable iff (rst_i) rfsw_sel_o == !vna_m)
    else begin
      value_errs = value_errs + 1;
      $display("FAIL %0t rfsw_sel_o expected %b actual %b", $time,
               !$sampled(vna_m), $sampled(rfsw_sel_o));
    end

  a_tune: assert property (@(posedge clk) disable iff (rst_i) auto_tune_o == tune_m)
    else begin
      value_errs = value_errs + 1;
      $display("FAIL %0t auto_tune_o expected %b actual %b", $time,
               $sampled(tune_m), $sampled(auto_tune_o));
    end

  // PA enables follow env_op_o unless VNA mode blocks them
  a_pa: assert property (@(posedge clk) disable iff (rst_i)
    pa_inttr_o == (env_op_o & !vna_m) && env_pa_o == (env_op_o & !vna_m) && pa_exttr_o == env_op_o)
    else begin
      value_errs = value_errs + 1;
      $display("FAIL %0t pa_inttr_o expected %b actual %b", $time,
               $sampled(env_op_o) & !$sampled(vna_m), $sampled(pa_inttr_o));
    end

  a_ptt: assert property (@(posedge clk) disable iff (rst_i)
    (ptt_phase && pin_age >= SETTLE) |-> tx_on_o == exp_tx)
    else begin
      value_errs = value_errs + 1;
      $display("FAIL %0t tx_on_o expected %b actual %b", $time,
               $sampled(exp_tx), $sampled(tx_on_o));
    end

  a_power_fast: assert property (@(posedge clk) disable iff (rst_i)
    (!pins_q[0] && pin_age >= 2) |-> env_op_o)
    else begin
      value_errs = value_errs + 1;
      $display("FAIL %0t env_op_o expected 1 actual %b", $time, $sampled(env_op_o));
    end

  a_keydown_window: assert property (@(posedge clk) disable iff (rst_i)
    $rose(cw_keydown_o) |->
      (!pins_q[0] && int'(pin_age) + 1 >= CW_EARLY && int'(pin_age) + 1 <= CW_LATE))
    else begin
      value_errs = value_errs + 1;
      $display("FAIL %0t cw_keydown_o rose %0d clocks after key press, expected %0d to %0d",
               $time, int'($sampled(pin_age)) + 1, CW_EARLY, CW_LATE);
    end

  a_hang_hold: assert property (@(posedge clk) disable iff (rst_i)
    (hang_chk && pins_q[0] && int'(pin_age) < hold_min) |-> env_op_o)
    else begin
      value_errs = value_errs + 1;
      $display("FAIL %0t env_op_o expected 1 actual %b", $time, $sampled(env_op_o));
    end

  a_hang_drop: assert property (@(posedge clk) disable iff (rst_i)
    (hang_chk && pins_q[0] && int'(pin_age) >= hold_max) |-> !env_op_o)
    else begin
      value_errs = value_errs + 1;
      $display("FAIL %0t env_op_o expected 0 actual %b", $time, $sampled(env_op_o));
    end

  a_resp: assert property (@(posedge clk) disable iff (rst_i) resp_chk |-> resp_o == exp_resp)
    else begin
      value_errs = value_errs + 1;
      $display("FAIL %0t resp_o expected %h actual %h", $time,
               $sampled(exp_resp), $sampled(resp_o));
    end

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic send_cmd(input control_pkg::cmd_addr_t addr, input control_pkg::cmd_data_t data,
                          input logic ptt, input logic need_resp);
    @(posedge clk);
    cmd_rqst_i          <= 1'b1;
    cmd_addr_i          <= addr;
    cmd_data_i          <= data;
    cmd_ptt_i           <= ptt;
    cmd_requires_resp_i <= need_resp;
    @(posedge clk);
    cmd_rqst_i          <= 1'b0;
    cmd_requires_resp_i <= 1'b0;
  endtask

  task automatic read_status();
    @(posedge clk);
    resp_rqst_i <= 1'b1;
    @(posedge clk);
    resp_rqst_i <= 1'b0;
    @(posedge clk);
  endtask

  // Drive the key pins and let them pass the debouncers
  task automatic set_pins(input logic tip, input logic ring, input logic cn8);
    @(posedge clk);
    phone_tip_i  <= tip;
    phone_ring_i <= ring;
    cn8_i        <= cn8;
    tick(SETTLE + 2);
  endtask

  task automatic wait_keydown(input int limit);
    int n;
    n = 0;
    while (!cw_keydown_o && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!cw_keydown_o) begin
      other_errs = other_errs + 1;
      $display("cw_keydown_o did not rise within %0d clocks of the key press", limit);
    end
  endtask

  task automatic wait_env_off(input int limit);
    int n;
    n = 0;
    while (env_op_o && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (env_op_o) begin
      other_errs = other_errs + 1;
      $display("env_op_o still high %0d clocks after key release", limit);
    end
  endtask

  initial begin
    control_pkg::cmd_data_t data;
    control_pkg::hang_t     hang;
    void'($urandom(32'h2563_a36b));
    value_errs = 0;
    other_errs = 0;
    rst_i <= 1'b1;
    cmd_rqst_i <= 1'b0;
    cmd_addr_i <= '0;
    cmd_data_i <= '0;
    cmd_ptt_i <= 1'b0;
    cmd_requires_resp_i <= 1'b0;
    resp_rqst_i <= 1'b0;
    run_i <= 1'b0;
    rxclip_i <= 1'b0;
    phone_tip_i <= 1'b1;
    phone_ring_i <= 1'b1;
    cn8_i <= 1'b1;
    fwd_pwr_i <= 12'($urandom);
    rev_pwr_i <= 12'($urandom);
    bias_current_i <= 12'($urandom);
    temperature_i <= 12'($urandom);
    ptt_phase <= 1'b0;
    hang_chk <= 1'b0;
    tick(10);
    rst_i <= 1'b0;
    tick(SETTLE);

    // VNA and auto-tune on while transmitting
    data = $urandom;
    data[control_pkg::CFG_VNA_BIT]  = 1'b1;
    data[control_pkg::CFG_TUNE_BIT] = 1'b1;
    send_cmd(control_pkg::CMD_ADDR_CONFIG, data, 1'b1, 1'b0);
    run_i <= 1'b1;
    tick(8);
    data = $urandom;
    data[control_pkg::CFG_VNA_BIT]  = 1'b0;
    data[control_pkg::CFG_TUNE_BIT] = 1'b0;
    send_cmd(control_pkg::CMD_ADDR_CONFIG, data, 1'b1, 1'b0);
    tick(8);

    // PTT sources against inhibit and run
    ptt_phase <= 1'b1;
    send_cmd(6'h00, $urandom, 1'b0, 1'b0);
    set_pins(1'b1, 1'b0, 1'b1);
    set_pins(1'b1, 1'b0, 1'b0);
    send_cmd(6'h00, $urandom, 1'b1, 1'b0);
    set_pins(1'b1, 1'b1, 1'b0);
    set_pins(1'b1, 1'b1, 1'b1);
    run_i <= 1'b0;
    tick(4);
    run_i <= 1'b1;
    send_cmd(6'h00, $urandom, 1'b0, 1'b0);
    tick(4);
    ptt_phase <= 1'b0;
    run_i <= 1'b0;

    // CW key delay then two-phase hang after release
    hang = 10'($urandom_range(4, 24));
    data = $urandom;
    data[31:24] = hang[9:2];
    data[17:16] = hang[1:0];
    send_cmd(control_pkg::CMD_ADDR_CWHANG, data, 1'b0, 1'b0);
    tick(SETTLE);
    phone_tip_i <= 1'b0;
    wait_keydown(CW_LATE + 8);
    tick(4);
    phone_tip_i <= 1'b1;
    @(posedge clk);
    hang_chk <= 1'b1;
    wait_env_off(hold_max + 16);
    tick(SETTLE + 4);
    hang_chk <= 1'b0;

    // Slot rotation and clip flag
    fwd_pwr_i <= 12'($urandom);
    rev_pwr_i <= 12'($urandom);
    bias_current_i <= 12'($urandom);
    temperature_i <= 12'($urandom);
    tick(2);
    repeat (4) read_status();
    rxclip_i <= 1'b1;
    tick(4);
    rxclip_i <= 1'b0;
    repeat (5) read_status();

    // Echo, overwrite, and capture in the same cycle as a read
    send_cmd(6'($urandom_range(32, 63)), $urandom, 1'b0, 1'b1);
    read_status();
    read_status();
    send_cmd(6'($urandom_range(32, 63)), $urandom, 1'b0, 1'b1);
    send_cmd(6'($urandom_range(32, 63)), $urandom, 1'b0, 1'b1);
    read_status();
    send_cmd(6'($urandom_range(32, 63)), $urandom, 1'b0, 1'b1);
    cmd_rqst_i <= 1'b1;
    cmd_requires_resp_i <= 1'b1;
    cmd_addr_i <= 6'($urandom_range(32, 63));
    cmd_data_i <= $urandom;
    resp_rqst_i <= 1'b1;
    @(posedge clk);
    cmd_rqst_i <= 1'b0;
    cmd_requires_resp_i <= 1'b0;
    resp_rqst_i <= 1'b0;
    read_status();
    read_status();
    tick(4);

    $display("Error counts: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
verilog/control_pkg.sv
verilog/debounce.sv
verilog/key_inputs.sv
verilog/cmd_decode.sv
verilog/tx_sequencer.sv
verilog/resp_builder.sv
verilog/control_top.sv
test/tb_control.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the control testbench with Verilator, verdict taken from the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_control \
  -f verilog.f -Mdir obj_dir > "$LOG" 2>&1 &&
  ./obj_dir/Vtb_control >> "$LOG" 2>&1

grep -q "Simulation finished: PASS" "$LOG" &&
  echo "Run passed, see $LOG" ||
  { echo "Run failed, see $LOG"; exit 1; }
